//--- include/riscv_pipe_config.svh
`ifndef RISCV_PIPE_CONFIG_SVH
`define RISCV_PIPE_CONFIG_SVH

// datapath and register file geometry
`define RP_XLEN       32
`define RP_NUM_REGS   32
`define RP_REG_ADDR_W 5

// fetch sequencing
`define RP_RESET_PC   32'h0000_0000
`define RP_PC_STEP    32'd4
`define RP_NOP_INST   32'h0000_0013 // addi x0, x0, 0

`endif

//--- hdl/riscv_pipe_pkg.sv
`include "riscv_pipe_config.svh"

package riscv_pipe_pkg;

    typedef logic [`RP_XLEN-1:0]       word_t;
    typedef logic [`RP_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // lui
    } alu_op_e;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;   // immediate as operand b
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- hdl/bypass_if.sv
`timescale 1ns/1ns

interface bypass_if;
    import riscv_pipe_pkg::*;

    // instruction in execute
    reg_addr_t ex_rd;
    logic      ex_reg_write;
    logic      ex_mem_read;
    word_t     ex_result;

    // instruction in memory stage
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      mem_mem_read;
    word_t     mem_result;

    // instruction in write-back
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_data;

    modport pipe (
        output ex_rd, ex_reg_write, ex_mem_read, ex_result,
        output mem_rd, mem_reg_write, mem_mem_read, mem_result,
        output wb_rd, wb_reg_write, wb_data
    );

    modport id_view (
        input ex_rd, ex_reg_write, ex_mem_read, ex_result,
        input mem_rd, mem_reg_write, mem_mem_read, mem_result,
        input wb_rd, wb_reg_write, wb_data
    );

    modport ex_view (
        input mem_rd, mem_reg_write, mem_result,
        input wb_rd, wb_reg_write, wb_data
    );

endinterface

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`include "riscv_pipe_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  riscv_pipe_pkg::reg_addr_t rs1_addr,
    input  riscv_pipe_pkg::reg_addr_t rs2_addr,
    input  riscv_pipe_pkg::reg_addr_t rd_addr,
    input  riscv_pipe_pkg::word_t     rd_data,
    input  logic                      rd_write,
    output riscv_pipe_pkg::word_t     rs1_data,
    output riscv_pipe_pkg::word_t     rs2_data
);
    import riscv_pipe_pkg::*;

    word_t regs [`RP_NUM_REGS];
    logic  wr_en;

    assign wr_en = rd_write && (rd_addr != '0); // x0 never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // write-back result visible in decode the same cycle
    assign rs1_data = (wr_en && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = (wr_en && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1_addr == '0) |-> (rs1_data == '0));

endmodule

//--- hdl/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  riscv_pipe_pkg::word_t     inst,
    output riscv_pipe_pkg::ctrl_t     ctrl,
    output riscv_pipe_pkg::word_t     imm,
    output riscv_pipe_pkg::reg_addr_t rs1,
    output riscv_pipe_pkg::reg_addr_t rs2,
    output riscv_pipe_pkg::reg_addr_t rd
);
    import riscv_pipe_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    // shared by register and immediate forms
    function automatic alu_op_e arith_op(logic [2:0] f3, logic alt, logic is_imm);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && !is_imm) ? ALU_SUB : ALU_ADD; // no subi
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = opcode_e'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign rd        = inst[11:7];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];

    always_comb begin
        ctrl = '0; // unknown opcodes act as a bubble
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(funct3, funct7_b5, 1'b0);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = arith_op(funct3, funct7_b5, 1'b1);
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1; // base + offset
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
            end
            default: ctrl = '0; // branches finish in decode
        endcase
    end

    // ========================================
    // immediate generator
    // ========================================
    always_comb begin
        case (opcode)
            OPC_OP_IMM,
            OPC_LOAD:   imm = {{20{inst[31]}}, inst[31:20]};
            OPC_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_LUI:    imm = {inst[31:12], 12'b0};
            default:    imm = '0;
        endcase
    end

endmodule

//--- hdl/branch_hazard_unit.sv
`timescale 1ns/1ns

module branch_hazard_unit (
    input  riscv_pipe_pkg::word_t inst,
    input  riscv_pipe_pkg::word_t pc,
    input  riscv_pipe_pkg::word_t imm,
    input  riscv_pipe_pkg::word_t rs1_data,
    input  riscv_pipe_pkg::word_t rs2_data,
    bypass_if.id_view             byp,
    output logic                  stall,
    output logic                  branch_taken,
    output riscv_pipe_pkg::word_t branch_target
);
    import riscv_pipe_pkg::*;

    opcode_e   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      is_branch;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      load_ex_hit;
    logic      load_mem_hit;
    logic      cond;
    word_t     op_a;
    word_t     op_b;

    // newest producer wins
    function automatic word_t fwd_operand(reg_addr_t rs, word_t reg_data);
        word_t val;
        val = reg_data;
        if (rs != '0) begin
            if (byp.ex_reg_write && byp.ex_rd == rs) val = byp.ex_result;
            else if (byp.mem_reg_write && byp.mem_rd == rs) val = byp.mem_result;
            else if (byp.wb_reg_write && byp.wb_rd == rs) val = byp.wb_data;
        end
        return val;
    endfunction

    assign opcode    = opcode_e'(inst[6:0]);
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign is_branch = (opcode == OPC_BRANCH);
    assign uses_rs1  = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
    assign uses_rs2  = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

    always_comb begin
        op_a = fwd_operand(rs1, rs1_data);
        op_b = fwd_operand(rs2, rs2_data);
    end

    always_comb begin
        case (inst[14:12])
            3'b000:  cond = (op_a == op_b);                   // beq
            3'b001:  cond = (op_a != op_b);                   // bne
            3'b100:  cond = ($signed(op_a) < $signed(op_b));  // blt
            3'b101:  cond = ($signed(op_a) >= $signed(op_b)); // bge
            3'b110:  cond = (op_a < op_b);                    // bltu
            3'b111:  cond = (op_a >= op_b);                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    // ========================================
    // load hazards
    // ========================================
    // load data only comes back through write-back
    assign load_ex_hit = byp.ex_mem_read && (byp.ex_rd != '0) &&
                         ((uses_rs1 && byp.ex_rd == rs1) || (uses_rs2 && byp.ex_rd == rs2));
    assign load_mem_hit = is_branch && byp.mem_mem_read && (byp.mem_rd != '0) &&
                          (byp.mem_rd == rs1 || byp.mem_rd == rs2);

    assign stall         = load_ex_hit || load_mem_hit;
    assign branch_taken  = is_branch && cond && !stall;
    assign branch_target = pc + imm;

endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  riscv_pipe_pkg::ctrl_t     ctrl,
    input  riscv_pipe_pkg::reg_addr_t rs1_addr,
    input  riscv_pipe_pkg::reg_addr_t rs2_addr,
    input  riscv_pipe_pkg::word_t     rs1_data,
    input  riscv_pipe_pkg::word_t     rs2_data,
    input  riscv_pipe_pkg::word_t     imm,
    bypass_if.ex_view                 byp,
    output riscv_pipe_pkg::word_t     alu_result,
    output riscv_pipe_pkg::word_t     store_data
);
    import riscv_pipe_pkg::*;

    fwd_sel_e   sel_a;
    fwd_sel_e   sel_b;
    word_t      op_a;
    word_t      rs2_fwd;
    word_t      op_b;
    logic [4:0] shamt;

    function automatic fwd_sel_e pick_src(reg_addr_t rs);
        if (rs == '0) return FWD_REG;
        if (byp.mem_reg_write && byp.mem_rd == rs) return FWD_MEM;
        if (byp.wb_reg_write && byp.wb_rd == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        sel_a = pick_src(rs1_addr);
        sel_b = pick_src(rs2_addr);
        case (sel_a)
            FWD_MEM: op_a = byp.mem_result;
            FWD_WB:  op_a = byp.wb_data;
            default: op_a = rs1_data;
        endcase
        case (sel_b)
            FWD_MEM: rs2_fwd = byp.mem_result;
            FWD_WB:  rs2_fwd = byp.wb_data;
            default: rs2_fwd = rs2_data;
        endcase
    end

    assign op_b       = ctrl.alu_src ? imm : rs2_fwd;
    assign shamt      = op_b[4:0];
    assign store_data = rs2_fwd; // sw data follows the same bypass

    // ========================================
    // alu
    // ========================================
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = word_t'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

endmodule

//--- hdl/riscv_pipe_top.sv
`timescale 1ns/1ns
`include "riscv_pipe_config.svh"

module riscv_pipe_top (
    input  logic                  clk,
    input  logic                  rst,
    output riscv_pipe_pkg::word_t imem_addr,
    input  riscv_pipe_pkg::word_t imem_data,
    output riscv_pipe_pkg::word_t dmem_addr,
    output logic                  dmem_read,
    output logic                  dmem_write,
    output riscv_pipe_pkg::word_t dmem_wdata,
    input  riscv_pipe_pkg::word_t dmem_rdata
);
    import riscv_pipe_pkg::*;

    word_t     pc;
    word_t     if_id_pc;
    word_t     if_id_inst;

    ctrl_t     id_ex_ctrl;
    reg_addr_t id_ex_rs1;
    reg_addr_t id_ex_rs2;
    reg_addr_t id_ex_rd;
    word_t     id_ex_rs1_data;
    word_t     id_ex_rs2_data;
    word_t     id_ex_imm;

    ctrl_t     ex_mem_ctrl;
    reg_addr_t ex_mem_rd;
    word_t     ex_mem_result;
    word_t     ex_mem_store_data;

    logic      mem_wb_reg_write;
    logic      mem_wb_mem_to_reg;
    reg_addr_t mem_wb_rd;
    word_t     mem_wb_result;
    word_t     mem_wb_rdata;

    ctrl_t     dec_ctrl;
    word_t     dec_imm;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;
    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    word_t     alu_result;
    word_t     store_data;
    word_t     wb_data;

    bypass_if byp ();

    // ========================================
    // fetch
    // ========================================
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= `RP_RESET_PC;
            if_id_inst <= `RP_NOP_INST;
        end else if (branch_taken) begin
            pc         <= branch_target;
            if_id_inst <= `RP_NOP_INST; // squash wrong-path fetch
        end else if (!stall) begin
            pc         <= pc + `RP_PC_STEP;
            if_id_inst <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) if_id_pc <= pc;
    end

    // ========================================
    // decode
    // ========================================
    decode_unit i_decode (
        .inst (if_id_inst),
        .ctrl (dec_ctrl),
        .imm  (dec_imm),
        .rs1  (dec_rs1),
        .rs2  (dec_rs2),
        .rd   (dec_rd)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .rd_addr  (mem_wb_rd),
        .rd_data  (wb_data),
        .rd_write (mem_wb_reg_write),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    branch_hazard_unit i_branch_hazard (
        .inst          (if_id_inst),
        .pc            (if_id_pc),
        .imm           (dec_imm),
        .rs1_data      (rf_rs1_data),
        .rs2_data      (rf_rs2_data),
        .byp           (byp.id_view),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) id_ex_ctrl <= '0;
        else     id_ex_ctrl <= stall ? ctrl_t'('0) : dec_ctrl; // bubble on stall
    end

    always_ff @(posedge clk) begin
        id_ex_rs1      <= dec_rs1;
        id_ex_rs2      <= dec_rs2;
        id_ex_rd       <= dec_rd;
        id_ex_rs1_data <= rf_rs1_data;
        id_ex_rs2_data <= rf_rs2_data;
        id_ex_imm      <= dec_imm;
    end

    // ========================================
    // execute
    // ========================================
    execute_unit i_execute (
        .ctrl       (id_ex_ctrl),
        .rs1_addr   (id_ex_rs1),
        .rs2_addr   (id_ex_rs2),
        .rs1_data   (id_ex_rs1_data),
        .rs2_data   (id_ex_rs2_data),
        .imm        (id_ex_imm),
        .byp        (byp.ex_view),
        .alu_result (alu_result),
        .store_data (store_data)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) ex_mem_ctrl <= '0;
        else     ex_mem_ctrl <= id_ex_ctrl;
    end

    always_ff @(posedge clk) begin
        ex_mem_rd         <= id_ex_rd;
        ex_mem_result     <= alu_result;
        ex_mem_store_data <= store_data;
    end

    // ========================================
    // memory and write-back
    // ========================================
    assign dmem_addr  = ex_mem_result;
    assign dmem_read  = ex_mem_ctrl.mem_read;
    assign dmem_write = ex_mem_ctrl.mem_write;
    assign dmem_wdata = ex_mem_store_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_reg_write  <= 1'b0;
            mem_wb_mem_to_reg <= 1'b0;
        end else begin
            mem_wb_reg_write  <= ex_mem_ctrl.reg_write;
            mem_wb_mem_to_reg <= ex_mem_ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd     <= ex_mem_rd;
        mem_wb_result <= ex_mem_result;
        mem_wb_rdata  <= dmem_rdata;
    end

    assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_result;

    // bypass sources, one group per stage
    assign byp.ex_rd         = id_ex_rd;
    assign byp.ex_reg_write  = id_ex_ctrl.reg_write;
    assign byp.ex_mem_read   = id_ex_ctrl.mem_read;
    assign byp.ex_result     = alu_result;
    assign byp.mem_rd        = ex_mem_rd;
    assign byp.mem_reg_write = ex_mem_ctrl.reg_write;
    assign byp.mem_mem_read  = ex_mem_ctrl.mem_read;
    assign byp.mem_result    = ex_mem_result;
    assign byp.wb_rd         = mem_wb_rd;
    assign byp.wb_reg_write  = mem_wb_reg_write;
    assign byp.wb_data       = wb_data;

    a_dmem_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write));

endmodule

//--- tests/tb_riscv_pipe.sv
`timescale 1ns/1ns
`include "riscv_pipe_config.svh"

module tb_riscv_pipe;
    import riscv_pipe_pkg::*;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 512;
    localparam int WAIT_LIMIT = 500; // cycles per program

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    logic  dmem_read;
    logic  dmem_write;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t prog [$];
    word_t st_addr [$];  // observed stores, in order
    word_t st_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    int errors;
    int checks;
    int err_mark;
    int tests_run;
    int tests_failed;
    bit hung;

    riscv_pipe_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clk = ~clk;

    // ========================================
    // memory models
    // ========================================
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_read ? dmem[dmem_addr[10:2]] : 'x; // data only while strobed

    always @(negedge clk) begin
        if (!rst && dmem_write === 1'b1) begin
            dmem[dmem_addr[10:2]] = dmem_wdata;
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
    end

    task automatic check_word(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %08h expected %08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_addr(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, address %08h expected %08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic verify_strobe(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ========================================
    // reference rules and program builder
    // ========================================
    function automatic word_t sign_ext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_model(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic r_type(logic [2:0] f3, logic alt, reg_addr_t rd,
                          reg_addr_t rs1, reg_addr_t rs2);
        prog.push_back({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP});
    endtask

    task automatic i_type(opcode_e opc, logic [2:0] f3, reg_addr_t rd,
                          reg_addr_t rs1, logic [11:0] imm);
        prog.push_back({imm, rs1, f3, rd, opc});
    endtask

    task automatic store_word(reg_addr_t rs2, logic [11:0] addr);
        prog.push_back({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], OPC_STORE}); // base x0
    endtask

    task automatic load_word(reg_addr_t rd, logic [11:0] addr);
        i_type(OPC_LOAD, 3'b010, rd, 5'd0, addr);
    endtask

    task automatic branch_to(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
        prog.push_back({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH});
    endtask

    task automatic lui_upper(reg_addr_t rd, logic [19:0] upper);
        prog.push_back({upper, rd, OPC_LUI});
    endtask

    task automatic load_const(reg_addr_t rd, word_t v);
        word_t up;
        up = v + 32'h800; // addi sign-extends the low part
        lui_upper(rd, up[31:12]);
        i_type(OPC_OP_IMM, 3'b000, rd, rd, v[11:0]);
    endtask

    task automatic add_expected(word_t addr, word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        err_mark = errors;
    endtask

    task automatic fill_memories();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `RP_NOP_INST;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = word_t'(i * 4) ^ 32'h5A5A_0000;
        end
    endtask

    // program is copied in while the core sits in reset
    task automatic load_and_reset();
        branch_to(3'b000, 5'd0, 5'd0, 13'd0); // beq x0,x0,0 parks the core
        @(posedge clk);
        #1 rst = 1'b1;
        fill_memories();
        for (int i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end
        st_addr.delete();
        st_data.delete();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic finish_test(string name);
        int cycles;
        int n;
        n = exp_addr.size();
        cycles = 0;
        while (st_addr.size() < n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (st_addr.size() < n) begin
            hung = 1'b1;
            $display("%s: no progress, only %0d of %0d stores after %0d cycles",
                     name, st_addr.size(), n, cycles);
        end else begin
            repeat (10) @(posedge clk); // room for a store that should not be there
            if (st_addr.size() != n) begin
                errors++;
                $display("%s: saw %0d stores where %0d were expected",
                         name, st_addr.size(), n);
            end
            for (int i = 0; i < n; i++) begin
                check_addr(st_addr[i], exp_addr[i], $sformatf("%s store %0d", name, i));
                check_word(st_data[i], exp_data[i], $sformatf("%s store %0d", name, i));
            end
        end
        tests_run++;
        if (hung || errors != err_mark) tests_failed++;
        $display("test %-18s %s (%0d errors)", name,
                 (hung || errors != err_mark) ? "failed" : "ok", errors - err_mark);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic x0_and_reset();
        new_program();
        i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd123);
        lui_upper(5'd0, 20'hABCDE);
        store_word(5'd0, 12'h600);            // x0 right behind two writes to it
        r_type(3'b110, 1'b0, 5'd1, 5'd0, 5'd0);
        store_word(5'd1, 12'h604);
        add_expected(32'h600, 32'd0);
        add_expected(32'h604, 32'd0);
        load_and_reset();
        check_addr(imem_addr, `RP_RESET_PC, "first fetch");
        verify_strobe(dmem_read, 1'b0, "dmem_read after reset");
        verify_strobe(dmem_write, 1'b0, "dmem_write after reset");
        finish_test("x0_and_reset");
    endtask

    task automatic alu_ops();
        word_t       a;
        word_t       b;
        word_t       addr;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        a = $urandom();
        b = $urandom();
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        addr = 32'h100;
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101); // then sub, sra
            alt = (k >= 8);
            r_type(f3, alt, 5'd3, 5'd1, 5'd2);
            store_word(5'd3, addr[11:0]);
            add_expected(addr, alu_model(f3, alt, a, b));
            addr += 4;
        end
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : 3'b101;
            alt = (k == 8);
            imm = 12'($urandom());
            if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]}; // shamt
            i_type(OPC_OP_IMM, f3, 5'd4, 5'd1, imm);
            store_word(5'd4, addr[11:0]);
            add_expected(addr, alu_model(f3, alt, a, sign_ext12(imm)));
            addr += 4;
        end
        load_and_reset();
        finish_test("alu_ops");
    endtask

    task automatic forwarding_chains();
        word_t a;
        word_t e2;
        word_t e3;
        word_t e4;
        a  = $urandom();
        e2 = a + a;
        e3 = e2 ^ a;
        e4 = e3 - e2;
        new_program();
        load_const(5'd1, a);
        r_type(3'b000, 1'b0, 5'd2, 5'd1, 5'd1); // distance 1
        store_word(5'd2, 12'h200);              // fresh result stored
        r_type(3'b100, 1'b0, 5'd3, 5'd2, 5'd1); // distances 2 and 3
        prog.push_back(`RP_NOP_INST);
        r_type(3'b000, 1'b1, 5'd4, 5'd3, 5'd2);
        store_word(5'd4, 12'h204);
        r_type(3'b000, 1'b0, 5'd5, 5'd4, 5'd3);
        store_word(5'd5, 12'h208);
        add_expected(32'h200, e2);
        add_expected(32'h204, e4);
        add_expected(32'h208, e4 + e3);
        load_and_reset();
        finish_test("forwarding_chains");
    endtask

    task automatic load_use();
        word_t a;
        a = $urandom();
        new_program();
        load_const(5'd1, a);
        store_word(5'd1, 12'h300);
        load_word(5'd2, 12'h300);
        r_type(3'b000, 1'b0, 5'd3, 5'd2, 5'd1); // uses the load at once
        store_word(5'd3, 12'h304);
        load_word(5'd4, 12'h300);
        store_word(5'd4, 12'h308);
        add_expected(32'h300, a);
        add_expected(32'h304, a + a);
        add_expected(32'h308, a);
        load_and_reset();
        finish_test("load_use");
    endtask

    task automatic branch_conditions();
        logic [2:0] f3s [12];
        word_t      va [12];
        word_t      vb [12];
        word_t      marker;
        word_t      addr;
        f3s = '{3'b000, 3'b000, 3'b001, 3'b001, 3'b100, 3'b100,
                3'b101, 3'b101, 3'b110, 3'b110, 3'b111, 3'b111};
        va  = '{32'd5, 32'd5, 32'd7, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 32'd3,
                32'hFFFF_FFFF, 32'hFFFF_FFFB, 32'd3, 32'hFFFF_FFF0, 32'h8000_0000, 32'd1};
        vb  = '{32'd5, 32'd6, 32'hFFFF_FFFF, 32'hFFFF_FFFD, 32'd3, 32'hFFFF_FFFE,
                32'hFFFF_FFFF, 32'd4, 32'hFFFF_FFF0, 32'd3, 32'd1, 32'h8000_0000};
        marker = $urandom();
        new_program();
        load_const(5'd3, marker);
        for (int k = 0; k < 12; k++) begin
            addr = 32'h400 + 8 * k;
            load_const(5'd1, va[k]);
            load_const(5'd2, vb[k]);
            branch_to(f3s[k], 5'd1, 5'd2, 13'd8);
            store_word(5'd3, addr[11:0]);         // skipped slot
            store_word(5'd3, addr[11:0] + 12'd4);
            if (!branch_model(f3s[k], va[k], vb[k])) add_expected(addr, marker);
            add_expected(addr + 4, marker);
        end
        load_and_reset();
        finish_test("branch_conditions");
    endtask

    task automatic branch_after_load();
        word_t v;
        word_t w;
        v = $urandom();
        w = v ^ 32'h8000_0000; // flips the signed order
        new_program();
        load_const(5'd6, v);
        store_word(5'd6, 12'h500);
        load_const(5'd9, w);
        store_word(5'd9, 12'h514);
        load_word(5'd5, 12'h500);
        branch_to(3'b000, 5'd5, 5'd6, 13'd8); // load directly ahead
        store_word(5'd6, 12'h504);
        store_word(5'd6, 12'h508);
        load_word(5'd7, 12'h500);
        i_type(OPC_OP_IMM, 3'b000, 5'd8, 5'd0, 12'd1);
        branch_to(3'b001, 5'd7, 5'd6, 13'd8); // load two ahead
        store_word(5'd6, 12'h50C);
        store_word(5'd6, 12'h510);
        load_word(5'd10, 12'h514);
        branch_to(3'b100, 5'd10, 5'd6, 13'd8);
        store_word(5'd6, 12'h518);
        store_word(5'd6, 12'h51C);
        add_expected(32'h500, v);
        add_expected(32'h514, w);
        if (!branch_model(3'b000, v, v)) add_expected(32'h504, v);
        add_expected(32'h508, v);
        if (!branch_model(3'b001, v, v)) add_expected(32'h50C, v);
        add_expected(32'h510, v);
        if (!branch_model(3'b100, w, v)) add_expected(32'h518, v);
        add_expected(32'h51C, v);
        load_and_reset();
        finish_test("branch_after_load");
    endtask

    initial begin
        void'($urandom(93));
        clk          = 1'b0;
        rst          = 1'b1;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        fill_memories();

        x0_and_reset();
        if (!hung) alu_ops();
        if (!hung) forwarding_chains();
        if (!hung) load_use();
        if (!hung) branch_conditions();
        if (!hung) branch_after_load();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- riscv_pipe.f
+incdir+include
hdl/riscv_pipe_pkg.sv
hdl/bypass_if.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/branch_hazard_unit.sv
hdl/execute_unit.sv
hdl/riscv_pipe_top.sv
tests/tb_riscv_pipe.sv

//--- Bender.yml
package:
  name: riscv_pipe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/riscv_pipe_pkg.sv
      - hdl/bypass_if.sv
      - hdl/reg_file.sv
      - hdl/decode_unit.sv
      - hdl/branch_hazard_unit.sv
      - hdl/execute_unit.sv
      - hdl/riscv_pipe_top.sv
      - target: test
        files:
          - tests/tb_riscv_pipe.sv
